// ==== src.f ====
src/cpu_isa_pkg.sv
src/cpu_bus_pkg.sv
src/control_unit.sv
src/register_file.sv
src/alu.sv
src/load_store.sv
src/cpu_top.sv
verification/cpu_tb_properties.sv
verification/cpu_tb.sv

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_isa_pkg::core_state_e    i_state,
  input  cpu_isa_pkg::decoded_instr_t i_dec,
  input  cpu_isa_pkg::word_t          i_rs1_val,
  input  cpu_isa_pkg::word_t          i_rs2_val,
  input  cpu_isa_pkg::word_t          i_pc,
  output cpu_isa_pkg::word_t          o_result,
  output logic                        o_wr,
  output logic                        o_jump_taken,
  output cpu_isa_pkg::word_t          o_jump_target
);
  import cpu_isa_pkg::*;

  logic  exec;
  word_t op_a;
  word_t op_b;
  word_t alu_out;
  word_t pc_plus4;

  assign exec = (i_state == EXECUTE);

  // Operand select
  // Register B for R-type and branch compare, immediate otherwise
  assign op_a = i_rs1_val;
  assign op_b = ((i_dec.opcode == OP) || i_dec.is_branch) ? i_rs2_val : i_dec.imm;

  always_comb begin
    case (i_dec.alu_op)
      ADD:     alu_out = op_a + op_b;
      SUB:     alu_out = op_a - op_b;
      AND:     alu_out = op_a & op_b;
      OR:      alu_out = op_a | op_b;
      XOR:     alu_out = op_a ^ op_b;
      PASS_B:  alu_out = op_b;
      // Equality flag in bit 0
      CMP_EQ:  alu_out = {31'b0, op_a == op_b};
      default: alu_out = op_a + op_b;
    endcase
  end

  assign pc_plus4 = i_pc + 32'd4;

  // Link address for JAL
  assign o_result = i_dec.is_jal ? pc_plus4 : alu_out;

  // Loads write back through the memory path instead
  assign o_wr = exec && i_dec.writes_rd && !i_dec.is_load;

  // Branch and jump targets are both PC relative
  assign o_jump_target = i_pc + i_dec.imm;

  // Taken BEQ or any JAL
  assign o_jump_taken = exec && (i_dec.is_jal || (i_dec.is_branch && alu_out[0]));

endmodule

`default_nettype wire

// ==== src/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  logic                        i_fetch_dv,
  input  cpu_isa_pkg::word_t          i_instr,
  input  logic                        i_mem_done,
  input  logic                        i_jump_taken,
  input  cpu_isa_pkg::word_t          i_jump_target,
  output cpu_isa_pkg::core_state_e    o_state,
  output cpu_isa_pkg::word_t          o_pc,
  output cpu_isa_pkg::decoded_instr_t o_dec,
  output logic                        o_start_fetch
);
  import cpu_isa_pkg::*;

  word_t   ir;
  logic    boot_done;
  logic    exec_last;
  opcode_e opcode;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;

  // Last EXECUTE cycle
  // Memory ops wait for the bus, the rest take one cycle
  assign exec_last = (o_state == EXECUTE) &&
                     ((o_dec.is_load || o_dec.is_store) ? i_mem_done : 1'b1);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_state       <= FETCH;
      o_pc          <= RESET_PC;
      ir            <= '0;
      o_start_fetch <= 1'b0;
      boot_done     <= 1'b0;
    end else begin
      boot_done     <= 1'b1;
      // First fetch after reset, then one per return to FETCH
      o_start_fetch <= !boot_done || exec_last;
      case (o_state)
        FETCH: begin
          if (i_fetch_dv) begin
            ir      <= i_instr;
            o_state <= EXECUTE;
          end
        end
        EXECUTE: begin
          if (exec_last) begin
            o_state <= FETCH;
            o_pc    <= i_jump_taken ? i_jump_target : o_pc + 32'd4;
          end
        end
        default: o_state <= FETCH;
      endcase
    end
  end

  // Immediates per format
  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};
  assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  assign opcode = opcode_e'(ir[6:0]);

  always_comb begin
    o_dec.opcode    = opcode;
    o_dec.alu_op    = ADD;
    o_dec.rd        = ir[11:7];
    o_dec.rs1       = ir[19:15];
    o_dec.rs2       = ir[24:20];
    o_dec.imm       = imm_i;
    o_dec.writes_rd = 1'b0;
    o_dec.is_load   = 1'b0;
    o_dec.is_store  = 1'b0;
    o_dec.is_branch = 1'b0;
    o_dec.is_jal    = 1'b0;
    // Anything not matched stays a no-op
    case (opcode)
      OP: begin
        o_dec.writes_rd = 1'b1;
        // funct7 and funct3 together
        case ({ir[31:25], ir[14:12]})
          10'b0000000_000: o_dec.alu_op = ADD;
          10'b0100000_000: o_dec.alu_op = SUB;
          10'b0000000_100: o_dec.alu_op = XOR;
          10'b0000000_110: o_dec.alu_op = OR;
          10'b0000000_111: o_dec.alu_op = AND;
          default:         o_dec.writes_rd = 1'b0;
        endcase
      end
      // ADDI only
      OP_IMM: o_dec.writes_rd = (ir[14:12] == 3'b000);
      LUI: begin
        o_dec.writes_rd = 1'b1;
        o_dec.alu_op    = PASS_B;
        o_dec.imm       = imm_u;
      end
      // Word loads and stores only
      LOAD: begin
        o_dec.writes_rd = (ir[14:12] == 3'b010);
        o_dec.is_load   = (ir[14:12] == 3'b010);
      end
      STORE: begin
        o_dec.is_store = (ir[14:12] == 3'b010);
        o_dec.imm      = imm_s;
      end
      // BEQ only
      BRANCH: begin
        o_dec.is_branch = (ir[14:12] == 3'b000);
        o_dec.alu_op    = CMP_EQ;
        o_dec.imm       = imm_b;
      end
      JAL: begin
        o_dec.writes_rd = 1'b1;
        o_dec.is_jal    = 1'b1;
        o_dec.imm       = imm_j;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/cpu_bus_pkg.sv ====
`default_nettype none

package cpu_bus_pkg;

  // Request towards memory
  // Valid only together with the request strobe
  typedef struct packed {
    cpu_isa_pkg::word_t addr;
    // Store data, don't care on reads
    cpu_isa_pkg::word_t wdata;
    // Set for write, clear for read
    logic               write;
  } bus_req_t;

  // Answer from memory
  // Valid only together with the response strobe
  typedef struct packed {
    // Read data, ignored for write acks
    cpu_isa_pkg::word_t rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== src/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Register index, x0 to x31
  typedef logic [4:0] reg_idx_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  // ALU operations
  // PASS_B forwards the second operand for LUI
  typedef enum logic [2:0] {
    ADD    = 3'd0,
    SUB    = 3'd1,
    AND    = 3'd2,
    OR     = 3'd3,
    XOR    = 3'd4,
    PASS_B = 3'd5,
    CMP_EQ = 3'd6
  } alu_op_e;

  // Core FSM states
  typedef enum logic {
    FETCH   = 1'b0,
    EXECUTE = 1'b1
  } core_state_e;

  // Decoder output, held stable for the whole EXECUTE phase
  typedef struct packed {
    opcode_e  opcode;
    alu_op_e  alu_op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    // Sign-extended immediate of the instruction format
    word_t    imm;
    logic     writes_rd;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     is_jal;
  } decoded_instr_t;

  // First fetch address
  localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter int REG_COUNT = 32
) (
  input  logic                  i_clk,
  input  logic                  i_arst_n,
  input  logic                  i_bus_dv,
  input  cpu_bus_pkg::bus_rsp_t i_bus_rsp,
  output logic                  o_bus_dv,
  output cpu_bus_pkg::bus_req_t o_bus_req
);
  import cpu_isa_pkg::*;

  // Control unit outputs
  core_state_e    w_state;
  word_t          w_pc;
  decoded_instr_t w_dec;
  logic           w_start_fetch;

  // ALU results
  word_t          w_alu_result;
  logic           w_alu_wr;
  logic           w_jump_taken;
  word_t          w_jump_target;

  // Load/store returns
  logic           w_fetch_dv;
  word_t          w_instr;
  logic           w_mem_done;
  logic           w_load_dv;
  word_t          w_load_data;

  // Register read ports
  word_t          w_rs1_val;
  word_t          w_rs2_val;

  control_unit m_control_unit (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_fetch_dv(w_fetch_dv), .i_instr(w_instr), .i_mem_done(w_mem_done),
    .i_jump_taken(w_jump_taken), .i_jump_target(w_jump_target),
    .o_state(w_state), .o_pc(w_pc), .o_dec(w_dec), .o_start_fetch(w_start_fetch)
  );

  alu m_alu (
    .i_state(w_state), .i_dec(w_dec),
    .i_rs1_val(w_rs1_val), .i_rs2_val(w_rs2_val), .i_pc(w_pc),
    .o_result(w_alu_result), .o_wr(w_alu_wr),
    .o_jump_taken(w_jump_taken), .o_jump_target(w_jump_target)
  );

  // Sole bus master, shared by fetch and data
  load_store m_load_store (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_state(w_state), .i_start_fetch(w_start_fetch), .i_pc(w_pc), .i_dec(w_dec),
    .i_rs1_val(w_rs1_val), .i_rs2_val(w_rs2_val),
    .i_bus_dv(i_bus_dv), .i_bus_rsp(i_bus_rsp),
    .o_bus_dv(o_bus_dv), .o_bus_req(o_bus_req),
    .o_fetch_dv(w_fetch_dv), .o_instr(w_instr), .o_mem_done(w_mem_done),
    .o_load_dv(w_load_dv), .o_load_data(w_load_data)
  );

  register_file #(
    .REG_COUNT(REG_COUNT)
  ) m_register_file (
    .i_clk(i_clk), .i_arst_n(i_arst_n), .i_dec(w_dec),
    .i_alu_wr(w_alu_wr), .i_alu_result(w_alu_result),
    .i_load_dv(w_load_dv), .i_load_data(w_load_data),
    .o_rs1_val(w_rs1_val), .o_rs2_val(w_rs2_val)
  );

endmodule

`default_nettype wire

// ==== src/load_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  cpu_isa_pkg::core_state_e    i_state,
  input  logic                        i_start_fetch,
  input  cpu_isa_pkg::word_t          i_pc,
  input  cpu_isa_pkg::decoded_instr_t i_dec,
  input  cpu_isa_pkg::word_t          i_rs1_val,
  input  cpu_isa_pkg::word_t          i_rs2_val,
  input  logic                        i_bus_dv,
  input  cpu_bus_pkg::bus_rsp_t       i_bus_rsp,
  output logic                        o_bus_dv,
  output cpu_bus_pkg::bus_req_t       o_bus_req,
  output logic                        o_fetch_dv,
  output cpu_isa_pkg::word_t          o_instr,
  output logic                        o_mem_done,
  output logic                        o_load_dv,
  output cpu_isa_pkg::word_t          o_load_data
);
  import cpu_isa_pkg::*;

  // Tracks the single outstanding request
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    FETCH_WAIT = 2'd1,
    DATA_WAIT  = 2'd2
  } ls_state_e;

  ls_state_e ls_state;
  logic      start_data;
  logic      fetch_rsp;
  logic      data_rsp;

  // IDLE in EXECUTE only happens in the first EXECUTE cycle
  assign start_data = (ls_state == IDLE) && (i_state == EXECUTE) &&
                      (i_dec.is_load || i_dec.is_store);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ls_state <= IDLE;
      o_bus_dv <= 1'b0;
    end else begin
      // Single-cycle strobe
      o_bus_dv <= 1'b0;
      case (ls_state)
        IDLE: begin
          if (i_start_fetch) begin
            o_bus_dv <= 1'b1;
            ls_state <= FETCH_WAIT;
          end else if (start_data) begin
            o_bus_dv <= 1'b1;
            ls_state <= DATA_WAIT;
          end
        end
        FETCH_WAIT, DATA_WAIT: begin
          if (i_bus_dv) begin
            ls_state <= IDLE;
          end
        end
        default: ls_state <= IDLE;
      endcase
    end
  end

  // Request payload, captured with the strobe
  always_ff @(posedge i_clk) begin
    if (ls_state == IDLE) begin
      if (i_start_fetch) begin
        o_bus_req <= '{addr: i_pc, wdata: '0, write: 1'b0};
      end else if (start_data) begin
        // Effective address rs1 + imm
        o_bus_req <= '{addr: i_rs1_val + i_dec.imm, wdata: i_rs2_val,
                       write: i_dec.is_store};
      end
    end
  end

  // Response routing
  assign fetch_rsp = (ls_state == FETCH_WAIT) && i_bus_dv;
  assign data_rsp  = (ls_state == DATA_WAIT) && i_bus_dv;

  assign o_fetch_dv  = fetch_rsp;
  assign o_instr     = i_bus_rsp.rdata;
  // Ends LW and SW alike
  assign o_mem_done  = data_rsp;
  // IR is held during EXECUTE so the decode still names the load
  assign o_load_dv   = data_rsp && i_dec.is_load;
  assign o_load_data = i_bus_rsp.rdata;

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file #(
  // 16 for RV32E
  parameter int REG_COUNT = 32
) (
  input  logic                        i_clk,
  input  logic                        i_arst_n,
  input  cpu_isa_pkg::decoded_instr_t i_dec,
  input  logic                        i_alu_wr,
  input  cpu_isa_pkg::word_t          i_alu_result,
  input  logic                        i_load_dv,
  input  cpu_isa_pkg::word_t          i_load_data,
  output cpu_isa_pkg::word_t          o_rs1_val,
  output cpu_isa_pkg::word_t          o_rs2_val
);
  import cpu_isa_pkg::*;

  word_t regs [REG_COUNT];
  logic  wr_en;
  word_t wr_data;

  // Write-back select
  // Strobes are exclusive so the load path wins only when it fires
  assign wr_en   = i_alu_wr | i_load_dv;
  assign wr_data = i_load_dv ? i_load_data : i_alu_result;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (i_dec.rd != '0) && (int'(i_dec.rd) < REG_COUNT)) begin
      // x0 never written, stays zero from reset
      regs[i_dec.rd] <= wr_data;
    end
  end

  // Combinational read ports
  // Indices past the last register read as zero
  assign o_rs1_val = (int'(i_dec.rs1) < REG_COUNT) ? regs[i_dec.rs1] : '0;
  assign o_rs2_val = (int'(i_dec.rs2) < REG_COUNT) ? regs[i_dec.rs2] : '0;

endmodule

`default_nettype wire

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;

  localparam int    N_RANDOM    = 40;
  localparam int    PROG_LEN    = 1 + N_RANDOM + 32 + 1;
  localparam int    MEM_WORDS   = 2048;
  localparam word_t DATA_BASE   = 32'h0000_1000;
  localparam int    DUMP_OFS    = 256;
  localparam int    REQ_TIMEOUT = 64;
  localparam int    MAX_STEPS   = 4 * PROG_LEN;

  // Generated instruction kinds
  typedef enum logic [3:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_LUI, K_LW, K_SW, K_BEQ, K_JAL
  } kind_e;

  typedef struct packed {
    kind_e    kind;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
  } instr_t;

  // Expected request, cat is the test it counts for
  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic       write;
    logic [2:0] cat;
  } exp_req_t;

  logic     i_clk;
  logic     i_arst_n;
  logic     i_bus_dv;
  bus_rsp_t i_bus_rsp;
  logic     o_bus_dv;
  bus_req_t o_bus_req;

  instr_t   prog [PROG_LEN];
  word_t    mem [MEM_WORDS];
  word_t    model_mem [MEM_WORDS];
  word_t    mreg [32];
  exp_req_t exp_q [$];
  word_t    rng_state = 32'd18321;
  int       checks [1:5];
  int       errors [1:5];
  logic     hung;
  string    test_name [1:5] = '{"reset and first fetch", "fetch addresses",
                                "store data", "loads and x0", "register dump and self-jump"};

  cpu_top #(
    .REG_COUNT(32)
  ) i_cpu_top (
    .i_clk(i_clk), .i_arst_n(i_arst_n), .i_bus_dv(i_bus_dv), .i_bus_rsp(i_bus_rsp),
    .o_bus_dv(o_bus_dv), .o_bus_req(o_bus_req)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic word_t xorshift_next();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // RV32I encodings
  function automatic word_t encode(instr_t ins);
    case (ins.kind)
      K_ADD:  return {7'b0000000, ins.rs2, ins.rs1, 3'b000, ins.rd, 7'b0110011};
      K_SUB:  return {7'b0100000, ins.rs2, ins.rs1, 3'b000, ins.rd, 7'b0110011};
      K_AND:  return {7'b0000000, ins.rs2, ins.rs1, 3'b111, ins.rd, 7'b0110011};
      K_OR:   return {7'b0000000, ins.rs2, ins.rs1, 3'b110, ins.rd, 7'b0110011};
      K_XOR:  return {7'b0000000, ins.rs2, ins.rs1, 3'b100, ins.rd, 7'b0110011};
      K_ADDI: return {ins.imm[11:0], ins.rs1, 3'b000, ins.rd, 7'b0010011};
      K_LUI:  return {ins.imm[31:12], ins.rd, 7'b0110111};
      K_LW:   return {ins.imm[11:0], ins.rs1, 3'b010, ins.rd, 7'b0000011};
      K_SW:   return {ins.imm[11:5], ins.rs2, ins.rs1, 3'b010, ins.imm[4:0], 7'b0100011};
      K_BEQ:  return {ins.imm[12], ins.imm[10:5], ins.rs2, ins.rs1, 3'b000,
                      ins.imm[4:1], ins.imm[11], 7'b1100011};
      K_JAL:  return {ins.imm[20], ins.imm[10:1], ins.imm[11], ins.imm[19:12],
                      ins.rd, 7'b1101111};
      default: return 32'h0000_0013;
    endcase
  endfunction

  function automatic void build_program();
    instr_t ins;
    word_t  r;
    word_t  r2;
    int     target;
    prog[0] = '{kind: K_LUI, rd: 5'd1, rs1: '0, rs2: '0, imm: DATA_BASE};
    for (int k = 1; k <= N_RANDOM; k++) begin
      r  = xorshift_next();
      r2 = xorshift_next();
      // Destination x0 or x2..x7, never the base x1
      ins.rd  = (r[10:8] == 3'd1) ? 5'd0 : {2'b00, r[10:8]};
      ins.rs1 = {2'b00, r[13:11]};
      ins.rs2 = {2'b00, r[16:14]};
      ins.imm = {{20{r2[11]}}, r2[11:0]};
      case (r[20:17])
        4'd0, 4'd15: ins.kind = K_ADD;
        4'd1:        ins.kind = K_SUB;
        4'd2:        ins.kind = K_AND;
        4'd3:        ins.kind = K_OR;
        4'd4:        ins.kind = K_XOR;
        4'd5, 4'd6:  ins.kind = K_ADDI;
        4'd7:        ins.kind = K_LUI;
        4'd8, 4'd9:  ins.kind = K_LW;
        4'd10, 4'd11: ins.kind = K_SW;
        4'd12, 4'd13: ins.kind = K_BEQ;
        default:     ins.kind = K_JAL;
      endcase
      if (ins.kind == K_LUI) begin
        ins.imm = {r2[31:12], 12'b0};
      end
      // Small word offsets from the data base
      if (ins.kind inside {K_LW, K_SW}) begin
        ins.rs1 = 5'd1;
        ins.imm = {26'b0, r2[15:12], 2'b00};
      end
      // Forward only, never past the first dump store
      if (ins.kind inside {K_BEQ, K_JAL}) begin
        if (r[25:24] == 2'b00) begin
          ins.rs2 = ins.rs1;
        end
        target  = k + 1 + int'(r2[17:16] % 3);
        target  = (target > N_RANDOM + 1) ? N_RANDOM + 1 : target;
        ins.imm = word_t'((target - k) * 4);
      end
      prog[k] = ins;
    end
    for (int i = 0; i < 32; i++) begin
      prog[1 + N_RANDOM + i] = '{kind: K_SW, rd: '0, rs1: 5'd1, rs2: reg_idx_t'(i),
                                 imm: word_t'(DUMP_OFS + 4 * i)};
    end
    prog[PROG_LEN - 1] = '{kind: K_JAL, rd: '0, rs1: '0, rs2: '0, imm: '0};
    // Fill depends on every address bit
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      mem[i] = encode(prog[i]);
    end
    model_mem = mem;
  endfunction

  // ISA reference model, fills the expected request queue
  function automatic void run_model();
    word_t      pc;
    word_t      next_pc;
    word_t      addr;
    instr_t     ins;
    logic [2:0] cat;
    pc = RESET_PC;
    for (int i = 0; i < 32; i++) begin
      mreg[i] = '0;
    end
    for (int step = 0; step < MAX_STEPS; step++) begin
      ins = prog[pc[31:2]];
      cat = (step == 0) ? 3'd1 : ((ins.kind == K_JAL && ins.imm == 0) ? 3'd5 : 3'd2);
      exp_q.push_back('{addr: pc, wdata: '0, write: 1'b0, cat: cat});
      // Self-jump fetches itself once more
      if (ins.kind == K_JAL && ins.imm == 0) begin
        exp_q.push_back('{addr: pc, wdata: '0, write: 1'b0, cat: 3'd5});
        return;
      end
      next_pc = pc + 32'd4;
      addr    = mreg[ins.rs1] + ins.imm;
      case (ins.kind)
        K_ADD:  mreg[ins.rd] = mreg[ins.rs1] + mreg[ins.rs2];
        K_SUB:  mreg[ins.rd] = mreg[ins.rs1] - mreg[ins.rs2];
        K_AND:  mreg[ins.rd] = mreg[ins.rs1] & mreg[ins.rs2];
        K_OR:   mreg[ins.rd] = mreg[ins.rs1] | mreg[ins.rs2];
        K_XOR:  mreg[ins.rd] = mreg[ins.rs1] ^ mreg[ins.rs2];
        K_ADDI: mreg[ins.rd] = mreg[ins.rs1] + ins.imm;
        K_LUI:  mreg[ins.rd] = ins.imm;
        K_LW: begin
          exp_q.push_back('{addr: addr, wdata: '0, write: 1'b0, cat: 3'd4});
          mreg[ins.rd] = model_mem[addr[12:2]];
        end
        K_SW: begin
          // Random stores, then the dump with x0 counted under loads and x0
          cat = (pc[31:2] <= N_RANDOM) ? 3'd3 : ((ins.rs2 == 0) ? 3'd4 : 3'd5);
          exp_q.push_back('{addr: addr, wdata: mreg[ins.rs2], write: 1'b1, cat: cat});
          model_mem[addr[12:2]] = mreg[ins.rs2];
        end
        K_BEQ: begin
          if (mreg[ins.rs1] == mreg[ins.rs2]) begin
            next_pc = pc + ins.imm;
          end
        end
        K_JAL: begin
          mreg[ins.rd] = pc + 32'd4;
          next_pc      = pc + ins.imm;
        end
        default: ;
      endcase
      mreg[0] = '0;
      pc      = next_pc;
    end
  endfunction

  task automatic check_word(input int cat, input string name, input word_t got,
                            input word_t exp);
    checks[cat]++;
    assert (got === exp) else begin
      errors[cat]++;
      $display("Error %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Wait for one request, check it, answer after 1 to 4 cycles
  task automatic serve_request();
    int       waited;
    int       latency;
    exp_req_t e;
    bus_req_t req;
    waited = 0;
    @(posedge i_clk);
    while (!o_bus_dv && waited < REQ_TIMEOUT) begin
      @(posedge i_clk);
      waited++;
    end
    if (!o_bus_dv) begin
      $display("Hang: no bus request within %0d cycles, %0d requests still expected",
               REQ_TIMEOUT, exp_q.size());
      hung = 1'b1;
      return;
    end
    req = o_bus_req;
    e   = exp_q.pop_front();
    check_word(e.cat, "o_bus_req.addr", req.addr, e.addr);
    check_word(e.cat, "o_bus_req.write", {31'b0, req.write}, {31'b0, e.write});
    if (e.write) begin
      check_word(e.cat, "o_bus_req.wdata", req.wdata, e.wdata);
    end
    if (req.write) begin
      mem[req.addr[12:2]] = req.wdata;
    end
    latency = 1 + int'(xorshift_next() % 4);
    repeat (latency - 1) @(posedge i_clk);
    i_bus_dv  <= 1'b1;
    i_bus_rsp <= '{rdata: req.write ? 32'h0 : mem[req.addr[12:2]]};
    @(posedge i_clk);
    i_bus_dv  <= 1'b0;
  endtask

  initial begin
    int fails;
    int total;
    i_arst_n  <= 1'b0;
    i_bus_dv  <= 1'b0;
    i_bus_rsp <= '0;
    hung = 1'b0;
    for (int t = 1; t <= 5; t++) begin
      checks[t] = 0;
      errors[t] = 0;
    end
    build_program();
    run_model();
    repeat (2) @(posedge i_clk);
    i_arst_n <= 1'b1;
    while (exp_q.size() > 0 && !hung) begin
      serve_request();
    end
    fails = 0;
    total = 0;
    for (int t = 1; t <= 5; t++) begin
      $display("Test %0d, %s: %0d checks, %0d errors", t, test_name[t], checks[t], errors[t]);
      fails += errors[t];
      total += checks[t];
    end
    fails += int'(i_cpu_top.m_properties.violations);
    fails += hung ? 1 : 0;
    $display("Checks %0d, failures %0d, assertion failures %0d", total, fails,
             i_cpu_top.m_properties.violations);
    if (fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/cpu_tb_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb_properties (
  input logic i_clk,
  input logic i_arst_n,
  input logic i_req_dv,
  input logic i_rsp_dv
);

  // Set by a request strobe, cleared by its answer
  logic        outstanding;
  int unsigned violations = 0;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      outstanding <= 1'b0;
    end else if (i_req_dv) begin
      outstanding <= 1'b1;
    end else if (i_rsp_dv) begin
      outstanding <= 1'b0;
    end
  end

  // Only one request in flight
  no_overlap: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_req_dv |-> !outstanding)
    else begin
      $error("bus request issued while another one is outstanding");
      violations++;
    end

  // Answers only to a pending request
  rsp_after_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_rsp_dv |-> outstanding)
    else begin
      $error("bus response arrived with no request outstanding");
      violations++;
    end

  // Quiet bus while reset is held
  reset_quiet: assert property (@(posedge i_clk) !i_arst_n |-> !i_req_dv)
    else begin
      $error("bus request strobe seen during reset");
      violations++;
    end

endmodule

bind cpu_top cpu_tb_properties m_properties (
  .i_clk(i_clk),
  .i_arst_n(i_arst_n),
  .i_req_dv(o_bus_dv),
  .i_rsp_dv(i_bus_dv)
);

`default_nettype wire
